// File: Makefile
# Verilator build and run for the lane buffer testbench.
BIN := obj_dir/Vtb_lane_buffer

.PHONY: run clean

run: $(BIN)
	./$(BIN) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "STATUS: FAIL" sim.log
	grep -q "STATUS: PASS" sim.log

# Rebuilt only when a source, a header or the file list changes.
$(BIN): list.f $(wildcard src/*.sv src/*.svh verif/*.sv)
	verilator --binary --timing --assert --top-module tb_lane_buffer -f list.f

clean:
	rm -rf obj_dir sim.log

// File: list.f
+incdir+src
src/stream_pkg.sv
src/stream_fifo.sv
src/lane_demux.sv
src/packet_arbiter.sv
src/lane_buffer_top.sv
verif/tb_lane_buffer.sv

// File: src/lane_buffer_top.sv
// Four-lane packet buffer top level.
// Demux into per-lane FIFOs, then a round-robin packet arbiter.

`timescale 1ns/1ps

`include "stream_macros.svh"

module lane_buffer_top (
    input  logic                  clk,
    input  logic                  rst,
    // Input stream, steered by dest.
    input  stream_pkg::in_beat_t  in_beat,
    input  logic                  in_valid,
    output logic                  in_ready,
    // Output stream, tagged with src.
    output stream_pkg::out_beat_t out_beat,
    output logic                  out_valid,
    input  logic                  out_ready
);

    // ----------------------------------------
    // Internal nets
    // ----------------------------------------

    stream_pkg::lane_beat_t                     demux_beat;   // Shared write beat.
    logic [`STREAM_LANES-1:0]                   demux_valid;  // One-hot write strobe.
    logic [`STREAM_LANES-1:0]                   demux_ready;  // FIFO not-full flags.
    stream_pkg::lane_beat_t [`STREAM_LANES-1:0] fifo_beat;    // Registered lane heads.
    logic [`STREAM_LANES-1:0]                   fifo_valid;
    logic [`STREAM_LANES-1:0]                   fifo_ready;   // Driven by the arbiter.

    // ----------------------------------------
    // Input steering
    // ----------------------------------------

    lane_demux u_demux (
        .in_beat    (in_beat),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .lane_beat  (demux_beat),
        .lane_valid (demux_valid),
        .lane_ready (demux_ready)
    );

    // ----------------------------------------
    // Lane storage
    // ----------------------------------------

    // One FIFO per lane. Each holds 16 beats in memory plus one at its output.
    for (genvar i = 0; i < `STREAM_LANES; i++) begin : g_lane
        stream_fifo u_fifo (
            .clk       (clk),
            .rst       (rst),
            .in_beat   (demux_beat),
            .in_valid  (demux_valid[i]),
            .in_ready  (demux_ready[i]),
            .out_beat  (fifo_beat[i]),
            .out_valid (fifo_valid[i]),
            .out_ready (fifo_ready[i])
        );
    end

    // ----------------------------------------
    // Output merge
    // ----------------------------------------

    packet_arbiter u_arbiter (
        .clk        (clk),
        .rst        (rst),
        .lane_beat  (fifo_beat),
        .lane_valid (fifo_valid),
        .lane_ready (fifo_ready),
        .out_beat   (out_beat),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

endmodule

// File: src/lane_demux.sv
// Input stream demultiplexer.
// Strips dest from each beat and steers it to the matching lane FIFO.

`timescale 1ns/1ps

`include "stream_macros.svh"

module lane_demux (
    // Incoming stream with destination lane.
    input  stream_pkg::in_beat_t     in_beat,
    input  logic                     in_valid,
    output logic                     in_ready,
    // One shared beat bus and a valid/ready pair per lane.
    output stream_pkg::lane_beat_t   lane_beat,
    output logic [`STREAM_LANES-1:0] lane_valid,
    input  logic [`STREAM_LANES-1:0] lane_ready
);

    stream_pkg::lane_t dest;  // Lane chosen by the current beat.

    assign dest = in_beat.dest;

    // ----------------------------------------
    // Payload
    // ----------------------------------------

    // Every lane sees the same beat. Only the addressed lane gets a valid,
    // so the others ignore it.
    always_comb begin
        lane_beat.last = in_beat.last;
        lane_beat.user = in_beat.user;
        lane_beat.data = in_beat.data;
    end

    // ----------------------------------------
    // Handshake
    // ----------------------------------------

    // All lanes idle except the addressed one, which mirrors in_valid.
    always_comb begin
        lane_valid       = '0;
        lane_valid[dest] = in_valid;
    end

    // Back-pressure comes from the addressed lane alone.
    // A full lane stalls only beats heading to it.
    assign in_ready = lane_ready[dest];

endmodule

// File: src/packet_arbiter.sv
// Round-robin packet arbiter.
// Drains the lane FIFOs onto one stream and keeps a lane until its last beat.
// Each output beat carries the index of its source lane.

`timescale 1ns/1ps

`include "stream_macros.svh"

module packet_arbiter (
    input  logic                                       clk,
    input  logic                                       rst,
    // Lane side, one registered FIFO output per lane.
    input  stream_pkg::lane_beat_t [`STREAM_LANES-1:0] lane_beat,
    input  logic [`STREAM_LANES-1:0]                   lane_valid,
    output logic [`STREAM_LANES-1:0]                   lane_ready,
    // Merged output stream.
    output stream_pkg::out_beat_t                      out_beat,
    output logic                                       out_valid,
    input  logic                                       out_ready
);

    stream_pkg::lane_t grant;   // Last lane served, or the lane owning the lock.
    logic              locked;  // A packet is partly sent from grant.
    stream_pkg::lane_t sel;     // Lane presented this cycle.

    // ----------------------------------------
    // Lane selection
    // ----------------------------------------

    // Unlocked, scan the lanes after grant and take the first with a beat.
    // The scan ends on grant itself, so it is the lowest priority.
    always_comb begin
        stream_pkg::lane_t cand;
        logic              found;
        cand  = grant;
        found = 1'b0;
        sel   = grant;
        if (!locked) begin
            for (int k = 1; k <= `STREAM_LANES; k++) begin
                cand = stream_pkg::lane_t'(grant + k);  // Wraps at the lane count.
                if (!found && lane_valid[cand]) begin
                    sel   = cand;
                    found = 1'b1;
                end
            end
        end
    end

    // ----------------------------------------
    // Output path
    // ----------------------------------------

    // Tag the beat with the lane it comes from.
    always_comb begin
        out_beat.last = lane_beat[sel].last;
        out_beat.user = lane_beat[sel].user;
        out_beat.src  = sel;
        out_beat.data = lane_beat[sel].data;
    end

    assign out_valid = lane_valid[sel];  // No lane valid leaves out_valid low.

    // Only the presented lane may see the consumer's ready.
    always_comb begin
        lane_ready      = '0;
        lane_ready[sel] = out_ready;
    end

    // ----------------------------------------
    // Grant and lock state
    // ----------------------------------------

    // Start after the top lane so lane 0 is served first.
    always_ff @(posedge clk) begin
        if (rst) begin
            grant  <= stream_pkg::lane_t'(`STREAM_LANES - 1);
            locked <= 1'b0;
        end else if (out_valid && out_ready) begin
            grant  <= sel;             // Round-robin moves on from here.
            locked <= !out_beat.last;  // Hold the lane until the packet ends.
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    // Inside a packet a stalled beat must stay on the bus unchanged.
    // An unlocked offer may still move to a lane earlier in the round-robin order.
    a_out_stable: assert property (@(posedge clk) disable iff (rst)
        (locked && out_valid && !out_ready) |=> (out_valid && $stable(out_beat)))
        else $error("packet_arbiter: stalled beat changed");

endmodule

// File: src/stream_fifo.sv
// Lane FIFO for stripped stream beats.
// Wrap-bit pointers for full/empty, a memory and a registered output stage.

`timescale 1ns/1ps

`include "stream_macros.svh"

module stream_fifo (
    input  logic                   clk,
    input  logic                   rst,
    // Write side.
    input  stream_pkg::lane_beat_t in_beat,
    input  logic                   in_valid,
    output logic                   in_ready,
    // Read side, straight from a register.
    output stream_pkg::lane_beat_t out_beat,
    output logic                   out_valid,
    input  logic                   out_ready
);

    localparam int unsigned DEPTH = 1 << `STREAM_FIFO_AW;  // Memory entries.

    logic [`STREAM_FIFO_AW:0] wr_ptr;  // Top bit toggles on every wrap.
    logic [`STREAM_FIFO_AW:0] rd_ptr;
    logic [`STREAM_FIFO_AW:0] fill;    // Beats held in memory, not counting the output.
    logic                     full;
    logic                     empty;
    logic                     write;
    logic                     read;

    stream_pkg::lane_beat_t mem [DEPTH];

    // ----------------------------------------
    // Status
    // ----------------------------------------

    // Same index but different wrap bit means the writer is a whole lap ahead.
    assign full = (wr_ptr[`STREAM_FIFO_AW] != rd_ptr[`STREAM_FIFO_AW]) &&
                  (wr_ptr[`STREAM_FIFO_AW-1:0] == rd_ptr[`STREAM_FIFO_AW-1:0]);
    assign empty = (wr_ptr == rd_ptr);  // Identical pointers, nothing stored.
    assign fill  = wr_ptr - rd_ptr;     // Modulo arithmetic handles the wrap.

    assign write    = in_valid && !full;
    // Refill the output register when it is empty or being taken this cycle.
    assign read     = (out_ready || !out_valid) && !empty;
    assign in_ready = !full;

    // ----------------------------------------
    // Write side
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (write) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // Each accepted beat lands in the slot that the write pointer addresses.
    always_ff @(posedge clk) begin
        if (write) begin
            mem[wr_ptr[`STREAM_FIFO_AW-1:0]] <= in_beat;
        end
    end

    // ----------------------------------------
    // Read side
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (read) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (read) begin
            out_beat <= mem[rd_ptr[`STREAM_FIFO_AW-1:0]];  // Held while stalled.
        end
    end

    // The valid flag only moves when the consumer can see a new beat.
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (out_ready || !out_valid) begin
            out_valid <= !empty;
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    // The writer never gets more than one lap ahead of the reader.
    // A write into a full memory would push the fill past the depth.
    a_fill_bound: assert property (@(posedge clk) disable iff (rst)
        fill <= DEPTH)
        else $error("stream_fifo: fill %0d exceeds depth", fill);

endmodule

// File: src/stream_macros.svh
// Size definitions for the four-lane stream buffer.
// Data width, lane count and lane FIFO address width.

`ifndef STREAM_MACROS_SVH
`define STREAM_MACROS_SVH

// ----------------------------------------
// Payload
// ----------------------------------------

// Width of the data byte carried by every beat.
`define STREAM_DATA_W 8

// ----------------------------------------
// Lanes and storage
// ----------------------------------------

// Number of lanes behind the demux. The lane index is log2 of this.
`define STREAM_LANES 4

// Address width of each lane memory, 2**4 = 16 entries per lane.
`define STREAM_FIFO_AW 4

`endif

// File: src/stream_pkg.sv
// Shared stream types.
// Lane index plus the input, stored and output beat layouts.

`include "stream_macros.svh"

package stream_pkg;

    // Index of one lane, 2 bits for four lanes.
    typedef logic [$clog2(`STREAM_LANES)-1:0] lane_t;

    // Beat as it arrives, steered by dest.
    typedef struct packed {
        logic                      last;  // Final beat of a packet.
        logic                      user;  // Sideband bit, passed through untouched.
        lane_t                     dest;  // Target lane.
        logic [`STREAM_DATA_W-1:0] data;
    } in_beat_t;

    // Beat as held in a lane FIFO. dest is implied by the lane.
    typedef struct packed {
        logic                      last;
        logic                      user;
        logic [`STREAM_DATA_W-1:0] data;
    } lane_beat_t;

    // Beat as it leaves, tagged with the lane it was drained from.
    typedef struct packed {
        logic                      last;
        logic                      user;
        lane_t                     src;
        logic [`STREAM_DATA_W-1:0] data;
    } out_beat_t;

endpackage

// File: verif/tb_lane_buffer.sv
// Testbench for the four-lane packet buffer.
// Clock, reset, LCG stimulus, per-lane reference queues, output checker and watchdog.

`timescale 1ns/1ps

`include "stream_macros.svh"

module tb_lane_buffer;

    localparam logic [31:0] SEED = 32'h0a7e8ae0;
    // Beats per test: 18 single, up to 40x6 random, 9 ordered, 18 full, up to 405 stressed.
    localparam int MAX_BEATS   = 18 + 240 + 9 + 18 + 405;
    localparam int CYCLE_LIMIT = 4 * MAX_BEATS + 200;

    logic                  clk = 1'b0;
    logic                  rst;
    stream_pkg::in_beat_t  in_beat;
    logic                  in_valid;
    logic                  in_ready;
    stream_pkg::out_beat_t out_beat;
    logic                  out_valid;
    logic                  out_ready;

    logic [31:0]          stim_state;   // LCG state for beats and packets.
    logic [31:0]          ready_state;  // LCG state for out_ready gaps.
    logic [1:0]           ready_mode;   // 0 holds out_ready low, 1 high, 2 random.
    stream_pkg::in_beat_t lane_q [`STREAM_LANES][$];  // Accepted beats, one queue per lane.
    stream_pkg::lane_t    start_order [$];            // Source lane of every packet start.
    logic                 in_pkt;       // Output is inside a packet.
    stream_pkg::lane_t    pkt_src;      // Lane that owns the current packet.
    int                   cycles = 0;
    int                   errors;
    int                   checks;
    int                   tests;
    int                   failed_tests;

    lane_buffer_top DUT (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    always #20 clk = ~clk;  // 40 ns period.

    // ----------------------------------------
    // Random numbers and reference model
    // ----------------------------------------

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] stim_rand();
        stim_state = lcg_next(stim_state);
        return stim_state;  // Low bits are weak, callers use the upper ones.
    endfunction

    // The output beat is the input beat with dest renamed to src.
    function automatic stream_pkg::out_beat_t expected_beat(input stream_pkg::in_beat_t b);
        stream_pkg::out_beat_t exp;
        exp.last = b.last;
        exp.user = b.user;
        exp.src  = b.dest;
        exp.data = b.data;
        return exp;
    endfunction

    function automatic int queued();
        int total;
        total = 0;
        for (int l = 0; l < `STREAM_LANES; l++) begin
            total += lane_q[l].size();
        end
        return total;
    endfunction

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        assert (got == exp)
            else begin
                $display("FAILED %s: got %h expected %h", name, got, exp);
                errors++;
            end
    endtask

    task automatic check_output(input stream_pkg::out_beat_t got);
        stream_pkg::out_beat_t exp;
        checks++;
        if (in_pkt) begin  // A started packet must finish on the same lane.
            assert (got.src == pkt_src)
                else begin
                    $display("FAILED out_beat.src: got %h expected %h", got.src, pkt_src);
                    errors++;
                end
        end else begin
            start_order.push_back(got.src);
        end
        assert (lane_q[got.src].size() > 0)
            else begin
                $display("Lane %0d sent a beat that was never accepted.", got.src);
                errors++;
            end
        if (lane_q[got.src].size() > 0) begin
            exp = expected_beat(lane_q[got.src][0]);
            assert (got == exp)
                else begin
                    $display("FAILED out_beat: got %h expected %h", got, exp);
                    errors++;
                end
            void'(lane_q[got.src].pop_front());
        end
        in_pkt  = !got.last;
        pkt_src = got.src;
    endtask

    // Both streams are stable at the falling edge, a handshake seen here
    // completes on the next rising edge.
    always @(negedge clk) begin
        if (!rst) begin
            if (out_valid && out_ready) begin
                check_output(out_beat);
            end
            if (in_valid && in_ready) begin
                lane_q[in_beat.dest].push_back(in_beat);
            end
        end
    end

    // Watchdog.
    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the buffer stopped moving beats.", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // out_ready follows the mode, changed by the sequence only at a falling edge.
    always @(posedge clk) begin
        #2;
        case (ready_mode)
            2'd0: out_ready = 1'b0;
            2'd1: out_ready = 1'b1;
            default: begin
                ready_state = lcg_next(ready_state);
                out_ready   = (ready_state[31:30] != 2'b00);  // High three times in four.
            end
        endcase
    end

    // ----------------------------------------
    // Stimulus tasks
    // ----------------------------------------

    task automatic reset_dut();
        rst = 1'b1;
        repeat (5) @(posedge clk);
        #2;
        rst    = 1'b0;
        in_pkt = 1'b0;
    endtask

    task automatic set_ready(input logic [1:0] mode);
        @(negedge clk);
        ready_mode = mode;
        @(posedge clk);
        #2;
    endtask

    task automatic present_beat(input stream_pkg::lane_t dest, input logic last);
        logic [31:0] r;
        r = stim_rand();
        in_beat.last = last;
        in_beat.user = r[31];
        in_beat.dest = dest;
        in_beat.data = r[23:16];
        in_valid     = 1'b1;
    endtask

    // Holds the beat until the buffer takes it.
    task automatic drive_beat(input stream_pkg::lane_t dest, input logic last);
        logic taken;
        present_beat(dest, last);
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = in_ready;
            @(posedge clk);
            #2;
        end
        in_valid = 1'b0;
    endtask

    task automatic send_packet(input stream_pkg::lane_t dest, input int len);
        for (int i = 0; i < len; i++) begin
            drive_beat(dest, i == len - 1);
        end
    endtask

    // Returns once every accepted beat has left, or after 40 cycles without progress.
    task automatic wait_drain();
        int left;
        int stuck;
        stuck = 0;
        left  = queued();
        do begin
            @(posedge clk);
            if (queued() == left) stuck++;
            else stuck = 0;
            left = queued();
        end while (left != 0 && stuck < 40);
        #2;
        assert (left == 0)
            else begin
                $display("%0d accepted beats never came out of the buffer.", left);
                errors++;
            end
    endtask

    task automatic end_test(input string name, input int e0);
        tests++;
        if (errors != e0) failed_tests++;
        $display("Test %0d %s: %s, %0d errors", tests, name,
                 (errors == e0) ? "ok" : "mismatches", errors - e0);
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------

    initial begin
        int          e0;
        int          n;
        int          len;
        logic [31:0] r;
        logic        taken;
        in_beat      = '0;
        in_valid     = 1'b0;
        out_ready    = 1'b0;
        rst          = 1'b1;
        stim_state   = SEED;
        ready_state  = lcg_next(lcg_next(SEED));
        ready_mode   = 2'd0;
        in_pkt       = 1'b0;
        pkt_src      = '0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        failed_tests = 0;
        reset_dut();

        e0 = errors;
        @(negedge clk);
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("in_ready", in_ready, 1'b1);
        @(posedge clk);
        #2;
        end_test("after reset", e0);

        e0 = errors;
        set_ready(2'd1);
        for (int l = 0; l < `STREAM_LANES; l++) begin
            send_packet(stream_pkg::lane_t'(l), l + 3);
        end
        wait_drain();
        end_test("single packets", e0);

        e0 = errors;
        for (int p = 0; p < 40; p++) begin
            r = stim_rand();
            send_packet(stream_pkg::lane_t'(r[17:16]), 1 + int'(r[26:24]) % 6);
            if (r[31:29] == 3'b000) begin
                @(posedge clk);  // Idle gap on the input.
                #2;
            end
        end
        wait_drain();
        end_test("no interleaving", e0);

        // Fresh reset puts the round-robin pointer back on lane 3.
        e0 = errors;
        set_ready(2'd0);
        reset_dut();
        start_order.delete();
        send_packet(2'd2, 3);
        send_packet(2'd0, 3);
        send_packet(2'd3, 3);
        set_ready(2'd1);
        wait_drain();
        assert (start_order.size() == 3 && start_order[0] == 2'd0 &&
                start_order[1] == 2'd2 && start_order[2] == 2'd3)
            else begin
                $display("Packets left from lanes %p instead of 0, 2, 3.", start_order);
                errors++;
            end
        end_test("round-robin order", e0);

        // Output stalled, so lane 1 fills to 16 in memory plus its output register.
        e0 = errors;
        set_ready(2'd0);
        n     = 0;
        taken = 1'b1;
        while (taken && n < 20) begin
            present_beat(2'd1, (n % 4 == 3) || (n >= 16));
            @(negedge clk);
            taken = in_ready;
            if (taken) n++;
            @(posedge clk);
            #2;
        end
        assert (n == 17)
            else begin
                $display("Lane 1 took %0d beats before in_ready fell, 17 expected.", n);
                errors++;
            end
        repeat (2) begin
            @(negedge clk);
            check_bit("in_ready", in_ready, 1'b0);
            @(posedge clk);
            #2;
        end
        present_beat(2'd2, 1'b1);  // Another lane still takes beats.
        @(negedge clk);
        check_bit("in_ready", in_ready, 1'b1);
        @(posedge clk);
        #2;
        in_valid = 1'b0;
        set_ready(2'd1);
        wait_drain();
        end_test("full lane", e0);

        e0 = errors;
        set_ready(2'd2);
        n = 0;
        while (n < 400) begin
            r   = stim_rand();
            len = 1 + int'(r[26:24]) % 6;
            send_packet(stream_pkg::lane_t'(r[17:16]), len);
            n += len;
        end
        wait_drain();
        end_test("random back-pressure", e0);

        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
